/* Bender.yml */
package:
  name: loopback_selftest

sources:
  - files:
      - src/loopback_pkg.sv
      - src/byte_stream_if.sv
      - src/pkt_pattern_gen.sv
      - src/stream_fifo.sv
      - src/pkt_pattern_chk.sv
      - src/pkt_chk_array.sv
      - src/loopback_top.sv
  - target: test
    files:
      - verification/tb_loopback.sv

/* all.f */
src/loopback_pkg.sv
src/byte_stream_if.sv
src/pkt_pattern_gen.sv
src/stream_fifo.sv
src/pkt_pattern_chk.sv
src/pkt_chk_array.sv
src/loopback_top.sv
verification/tb_loopback.sv

/* src/byte_stream_if.sv */
/* one byte-stream link with valid/ready handshake
   src drives the beat, snk answers with tready */
`default_nettype none

interface byte_stream_if;

    // beat payload
    logic [loopback_pkg::DATA_W-1:0]     tdata;
    logic [loopback_pkg::DATA_BYTES-1:0] tkeep;
    logic                                tlast;

    // handshake
    logic                                tvalid;
    logic                                tready;

    // sending side
    modport src (
        output tdata, tkeep, tlast, tvalid,
        input  tready
    );

    // receiving side
    modport snk (
        input  tdata, tkeep, tlast, tvalid,
        output tready
    );

endinterface

`default_nettype wire

/* src/loopback_pkg.sv */
/* shared widths, FSM encodings and a tkeep helper for the stream loopback self-test
   design files refer to these by scoped name */
`default_nettype none

package loopback_pkg;

    // beat geometry
    // one 32-bit word per beat
    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = DATA_BYTES * 8;

    // packet length in bytes, legal range 1 to 255
    localparam int LEN_W = 8;

    // width of good and bad packet counters
    localparam int CNT_W = 16;

    // generator FSM
    typedef enum logic [0:0] {
        IDLE = 1'b0,    // waiting for start
        SEND = 1'b1     // beats going out
    } gen_state_t;

    // checker FSM
    typedef enum logic [0:0] {
        FIRST = 1'b0,   // next beat opens a packet
        BODY  = 1'b1    // somewhere inside a packet
    } chk_state_t;

    // tkeep for a beat given the bytes still owed in the packet
    // contiguous from byte 0, saturates at a full beat
    function automatic logic [DATA_BYTES-1:0] keep_mask(
        input logic [LEN_W-1:0] remaining
    );
        logic [DATA_BYTES-1:0] keep;
        keep = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep[i] = (remaining > i);
        end
        return keep;
    endfunction

endpackage

`default_nettype wire

/* src/loopback_top.sv */
/* loopback self-test top, per lane generator into FIFO into checker
   control and status as flat vectors with lane p in slice p */
`default_nettype none

module loopback_top #(
    parameter int NUM_PORTS  = 2,
    parameter int FIFO_DEPTH = 8
) (
    input  var logic                                    clk,
    input  var logic                                    rst,
    input  var logic [NUM_PORTS-1:0]                    start,
    input  var logic [NUM_PORTS*loopback_pkg::LEN_W-1:0] pkt_len,
    input  var logic [NUM_PORTS*8-1:0]                  first_byte,
    input  var logic [NUM_PORTS-1:0]                    err_inject,
    input  var logic [NUM_PORTS-1:0]                    chk_hold,
    output logic [NUM_PORTS-1:0]                        busy,
    output logic [NUM_PORTS*loopback_pkg::CNT_W-1:0]    good_cnt,
    output logic [NUM_PORTS*loopback_pkg::CNT_W-1:0]    bad_cnt,
    output logic [NUM_PORTS*loopback_pkg::LEN_W-1:0]    last_len,
    output logic                                        any_err
);

    localparam int LEN_W = loopback_pkg::LEN_W;

    // generator to FIFO
    byte_stream_if gen_link [NUM_PORTS] ();
    // FIFO to checker
    byte_stream_if chk_link [NUM_PORTS] ();

    generate
        for (genvar port = 0; port < NUM_PORTS; port++) begin : g_lane
            pkt_pattern_gen gen_i (
                .clk        ( clk                              ),
                .rst        ( rst                              ),
                .start      ( start[port]                      ),
                .pkt_len    ( pkt_len[port*LEN_W +: LEN_W]     ),
                .first_byte ( first_byte[port*8 +: 8]          ),
                .err_inject ( err_inject[port]                 ),
                .busy       ( busy[port]                       ),
                .m          ( gen_link[port]                   )
            );

            stream_fifo #(
                .FIFO_DEPTH ( FIFO_DEPTH )
            ) fifo_i (
                .clk ( clk            ),
                .rst ( rst            ),
                .s   ( gen_link[port] ),
                .m   ( chk_link[port] )
            );
        end
    endgenerate

    // all lanes checked in one array, shared error flag
    pkt_chk_array #(
        .NUM_PORTS ( NUM_PORTS )
    ) chk_array_i (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .hold     ( chk_hold ),
        .s        ( chk_link ),
        .good_cnt ( good_cnt ),
        .bad_cnt  ( bad_cnt  ),
        .last_len ( last_len ),
        .any_err  ( any_err  )
    );

endmodule

`default_nettype wire

/* src/pkt_chk_array.sv */
/* one packet checker per lane, results packed into flat per-lane buses
   any_err latches the first bad packet on any lane until reset */
`default_nettype none

module pkt_chk_array #(
    parameter int NUM_PORTS = 2
) (
    input  var logic                                    clk,
    input  var logic                                    rst,
    input  var logic [NUM_PORTS-1:0]                    hold,
    byte_stream_if.snk                                  s [NUM_PORTS],
    output logic [NUM_PORTS*loopback_pkg::CNT_W-1:0]    good_cnt,
    output logic [NUM_PORTS*loopback_pkg::CNT_W-1:0]    bad_cnt,
    output logic [NUM_PORTS*loopback_pkg::LEN_W-1:0]    last_len,
    output logic                                        any_err
);

    localparam int CNT_W = loopback_pkg::CNT_W;
    localparam int LEN_W = loopback_pkg::LEN_W;

    // one strobe per lane
    logic [NUM_PORTS-1:0] err_pulse;

    generate
        for (genvar port = 0; port < NUM_PORTS; port++) begin : g_chk
            pkt_pattern_chk chk_i (
                .clk       ( clk                              ),
                .rst       ( rst                              ),
                .hold      ( hold[port]                       ),
                .s         ( s[port]                          ),
                .good_cnt  ( good_cnt[port*CNT_W +: CNT_W]    ),
                .bad_cnt   ( bad_cnt[port*CNT_W +: CNT_W]     ),
                .last_len  ( last_len[port*LEN_W +: LEN_W]    ),
                .err_pulse ( err_pulse[port]                  )
            );
        end
    endgenerate

    // sticky, cleared only by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            any_err <= 1'b0;
        end else if (|err_pulse) begin
            any_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/pkt_pattern_chk.sv */
/* packet checker for one lane, tests byte continuity and measures length
   keeps good and bad counts plus the length of the last packet */
`default_nettype none

module pkt_pattern_chk (
    input  var logic                          clk,
    input  var logic                          rst,
    input  var logic                          hold,
    byte_stream_if.snk                        s,
    output logic [loopback_pkg::CNT_W-1:0]    good_cnt,
    output logic [loopback_pkg::CNT_W-1:0]    bad_cnt,
    output logic [loopback_pkg::LEN_W-1:0]    last_len,
    output logic                              err_pulse
);

    localparam int NB    = loopback_pkg::DATA_BYTES;
    localparam int LEN_W = loopback_pkg::LEN_W;

    loopback_pkg::chk_state_t state;

    // last kept byte of the previous beat
    logic [7:0]       prev_byte;
    // bytes seen so far in this packet
    logic [LEN_W-1:0] byte_cnt;
    // sticky within one packet
    logic             pkt_bad;
    logic             accept;

    // per-beat results
    logic [7:0]       ref_byte;
    logic [LEN_W-1:0] beat_len;
    logic             beat_bad;
    logic [LEN_W-1:0] len_sum;
    logic             bad_sum;

    // back-pressure straight from hold
    assign s.tready = !hold;
    assign accept   = s.tvalid && s.tready;

    // walk the kept bytes in order
    always_comb begin
        ref_byte = prev_byte;
        beat_bad = 1'b0;
        beat_len = '0;
        for (int i = 0; i < NB; i++) begin
            if (s.tkeep[i]) begin
                // byte 0 of a packet is the seed, nothing to compare
                if (!(state == loopback_pkg::FIRST && i == 0) &&
                    s.tdata[i*8 +: 8] != ref_byte + 8'd1) begin
                    beat_bad = 1'b1;
                end
                ref_byte = s.tdata[i*8 +: 8];
                beat_len = beat_len + 1'b1;
            end
        end
    end

    // totals including the current beat
    assign len_sum = ((state == loopback_pkg::FIRST) ? '0 : byte_cnt) + beat_len;
    assign bad_sum = ((state == loopback_pkg::BODY) && pkt_bad) || beat_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= loopback_pkg::FIRST;
            pkt_bad   <= 1'b0;
            good_cnt  <= '0;
            bad_cnt   <= '0;
            last_len  <= '0;
            err_pulse <= 1'b0;
        end else begin
            err_pulse <= 1'b0;
            if (accept) begin
                if (s.tlast) begin
                    // close the packet, results visible next cycle
                    state    <= loopback_pkg::FIRST;
                    last_len <= len_sum;
                    if (bad_sum) begin
                        bad_cnt   <= bad_cnt + 1'b1;
                        err_pulse <= 1'b1;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end else begin
                    state   <= loopback_pkg::BODY;
                    pkt_bad <= bad_sum;
                end
            end
        end
    end

    // running seed and length
    always_ff @(posedge clk) begin
        if (accept) begin
            prev_byte <= ref_byte;
            byte_cnt  <= len_sum;
        end
    end

    // only the closing beat of a packet may be partial
    a_full_keep: assert property (
        @(posedge clk) disable iff (rst)
        s.tvalid && !s.tlast |-> &s.tkeep
    );

endmodule

`default_nettype wire

/* src/pkt_pattern_gen.sv */
/* pattern generator, sends one packet of incrementing bytes per accepted start pulse
   optional error injection flips bit 0 of the first byte */
`default_nettype none

module pkt_pattern_gen (
    input  var logic                           clk,
    input  var logic                           rst,
    input  var logic                           start,
    input  var logic [loopback_pkg::LEN_W-1:0] pkt_len,
    input  var logic [7:0]                     first_byte,
    input  var logic                           err_inject,
    output logic                               busy,
    byte_stream_if.src                         m
);

    localparam int NB    = loopback_pkg::DATA_BYTES;
    localparam int LEN_W = loopback_pkg::LEN_W;

    loopback_pkg::gen_state_t state;

    // bytes still to send, counting the current beat
    logic [LEN_W-1:0]              bytes_left;
    // value of byte 0 in the current beat
    logic [7:0]                    next_byte;
    // set until the first beat has gone out
    logic                          inj_pending;
    logic [loopback_pkg::DATA_W-1:0] beat_data;
    logic                          xfer;

    assign xfer = m.tvalid && m.tready;

    // busy and tvalid rise together, one cycle after start
    assign busy     = (state == loopback_pkg::SEND);
    assign m.tvalid = busy;
    assign m.tlast  = (bytes_left <= NB);
    assign m.tkeep  = loopback_pkg::keep_mask(bytes_left);
    assign m.tdata  = beat_data;

    // byte i of the beat is next_byte + i, mod 256
    always_comb begin
        for (int i = 0; i < NB; i++) begin
            beat_data[i*8 +: 8] = next_byte + 8'(i);
        end
        // corrupt only the very first byte of the packet
        if (inj_pending) begin
            beat_data[0] = ~beat_data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= loopback_pkg::IDLE;
            inj_pending <= 1'b0;
        end else begin
            case (state)
                loopback_pkg::IDLE: begin
                    // start is ignored while busy
                    if (start) begin
                        state       <= loopback_pkg::SEND;
                        inj_pending <= err_inject;
                    end
                end
                loopback_pkg::SEND: begin
                    if (xfer) begin
                        inj_pending <= 1'b0;
                        if (m.tlast) begin
                            state <= loopback_pkg::IDLE;
                        end
                    end
                end
                default: state <= loopback_pkg::IDLE;
            endcase
        end
    end

    // packet position, only moves on start or on an accepted beat
    always_ff @(posedge clk) begin
        if (state == loopback_pkg::IDLE && start) begin
            bytes_left <= pkt_len;
            next_byte  <= first_byte;
        end else if (xfer) begin
            bytes_left <= bytes_left - LEN_W'(NB);
            next_byte  <= next_byte + 8'(NB);
        end
    end

    // a stalled beat must not change until the FIFO takes it
    a_stall_stable: assert property (
        @(posedge clk) disable iff (rst)
        m.tvalid && !m.tready |=>
            m.tvalid && $stable(m.tdata) && $stable(m.tkeep) && $stable(m.tlast)
    );

endmodule

`default_nettype wire

/* src/stream_fifo.sv */
/* first-word-fall-through FIFO for one byte-stream link
   tready on the input drops while all FIFO_DEPTH entries are in use */
`default_nettype none

module stream_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  var logic   clk,
    input  var logic   rst,
    byte_stream_if.snk s,
    byte_stream_if.src m
);

    localparam int NB = loopback_pkg::DATA_BYTES;
    localparam int DW = loopback_pkg::DATA_W;
    localparam int AW = $clog2(FIFO_DEPTH);
    // one entry holds {tlast, tkeep, tdata}
    localparam int EW = DW + NB + 1;

    logic [EW-1:0] mem [FIFO_DEPTH];

    // extra msb is the wrap bit
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          wr_en;
    logic          rd_en;
    logic [EW-1:0] rd_word;

    // same index on a different lap means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign s.tready = !full;
    assign wr_en    = s.tvalid && !full;

    // head entry shows without a read request
    assign m.tvalid = !empty;
    assign rd_en    = m.tready && !empty;
    assign rd_word  = mem[rd_ptr[AW-1:0]];
    assign {m.tlast, m.tkeep, m.tdata} = rd_word;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {s.tlast, s.tkeep, s.tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy stays within the depth so no write lands on a full FIFO
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (AW+1)'(wr_ptr - rd_ptr) <= FIFO_DEPTH
    );

endmodule

`default_nettype wire

/* verification/tb_loopback.sv */
/* table-driven testbench for loopback_top with a two-lane reference model
   drives rows of packets and checks counters at each packet end */
`default_nettype none

module tb_loopback;

    localparam int NUM_PORTS  = 2;
    localparam int FIFO_DEPTH = 8;
    localparam int NUM_ROWS   = 13;
    // hold modes
    localparam logic [1:0] HOLD_NONE = 2'd0;
    localparam logic [1:0] HOLD_LONG = 2'd1;
    localparam logic [1:0] HOLD_RAND = 2'd2;
    // well past the FIFO depth
    localparam int LONG_HOLD = 24;

    typedef struct packed {
        logic       port;
        logic [7:0] len;
        logic [7:0] first;
        logic       inject;
        logic [1:0] hold;
        logic       pair;       // starts together with the next row on the other lane
        logic       restart;    // second start pulse while busy
    } row_t;

    // port, len, first byte, inject, hold, pair, restart
    row_t rows [NUM_ROWS] = '{
        '{1'b0, 8'd1,   8'h00, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd3,   8'h10, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd4,   8'hfe, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd5,   8'hfd, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd255, 8'h80, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd7,   8'h20, 1'b1, HOLD_NONE, 1'b0, 1'b0},
        '{1'b0, 8'd45,  8'h40, 1'b0, HOLD_LONG, 1'b0, 1'b0},
        '{1'b1, 8'd255, 8'h01, 1'b0, HOLD_RAND, 1'b0, 1'b0},
        '{1'b1, 8'd13,  8'hf0, 1'b0, HOLD_LONG, 1'b0, 1'b1},
        '{1'b0, 8'd30,  8'h33, 1'b0, HOLD_RAND, 1'b1, 1'b0},
        '{1'b1, 8'd17,  8'hc8, 1'b0, HOLD_NONE, 1'b0, 1'b0},
        '{1'b1, 8'd6,   8'h77, 1'b1, HOLD_RAND, 1'b0, 1'b0},
        '{1'b0, 8'd2,   8'hff, 1'b0, HOLD_NONE, 1'b0, 1'b0}
    };

    logic                   clk;
    logic                   rst;
    logic [NUM_PORTS-1:0]   start;
    logic [NUM_PORTS*8-1:0] pkt_len;
    logic [NUM_PORTS*8-1:0] first_byte;
    logic [NUM_PORTS-1:0]   err_inject;
    logic [NUM_PORTS-1:0]   chk_hold = '0;
    logic [NUM_PORTS-1:0]   busy;
    logic [NUM_PORTS*16-1:0] good_cnt;
    logic [NUM_PORTS*16-1:0] bad_cnt;
    logic [NUM_PORTS*8-1:0] last_len;
    logic                   any_err;

    // hold driver state
    logic [1:0]  hold_mode [NUM_PORTS] = '{HOLD_NONE, HOLD_NONE};
    int          hold_cnt [NUM_PORTS] = '{0, 0};
    logic [31:0] lfsr_state = 32'h928a_4c93;

    // reference model
    int   exp_good [NUM_PORTS] = '{0, 0};
    int   exp_bad [NUM_PORTS]  = '{0, 0};
    int   exp_len [NUM_PORTS]  = '{0, 0};
    logic exp_err = 1'b0;
    int   err_cnt = 0;
    int   check_cnt = 0;
    int   p;

    loopback_top #(
        .NUM_PORTS  ( NUM_PORTS  ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) dut_i (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .start      ( start      ),
        .pkt_len    ( pkt_len    ),
        .first_byte ( first_byte ),
        .err_inject ( err_inject ),
        .chk_hold   ( chk_hold   ),
        .busy       ( busy       ),
        .good_cnt   ( good_cnt   ),
        .bad_cnt    ( bad_cnt    ),
        .last_len   ( last_len   ),
        .any_err    ( any_err    )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // checker back-pressure per lane
    always @(posedge clk) begin
        if (rst) begin
            chk_hold <= '0;
        end else begin
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (start[q]) begin
                    hold_cnt[q] <= LONG_HOLD;
                end else if (hold_cnt[q] != 0) begin
                    hold_cnt[q] <= hold_cnt[q] - 1;
                end
                case (hold_mode[q])
                    HOLD_LONG: chk_hold[q] <= (hold_cnt[q] != 0);
                    HOLD_RAND: begin
                        // one step per hold bit
                        lfsr_state = lfsr_next(lfsr_state);
                        chk_hold[q] <= lfsr_state[0];
                    end
                    default: chk_hold[q] <= 1'b0;
                endcase
            end
        end
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // drives one row on its lane and updates the model
    task launch_row(input row_t r);
        p = int'(r.port);
        pkt_len[p*8 +: 8]    <= r.len;
        first_byte[p*8 +: 8] <= r.first;
        err_inject[p]        <= r.inject;
        hold_mode[p]         <= r.hold;
        start[p]             <= 1'b1;
        if (r.inject) begin
            exp_bad[p]++;
            exp_err = 1'b1;
        end else begin
            exp_good[p]++;
        end
        exp_len[p] = r.len;
    endtask

    // packet done once busy is low and the count moved
    task wait_lane_done(input int q);
        do begin
            @(negedge clk);
        end while (busy[q] ||
                   int'(good_cnt[q*16 +: 16]) + int'(bad_cnt[q*16 +: 16]) !=
                   exp_good[q] + exp_bad[q]);
        // sticky error flag trails the count by one cycle
        @(negedge clk);
    endtask

    task check_lane(input int q);
        check_value($sformatf("good_cnt[%0d]", q), 32'(good_cnt[q*16 +: 16]), exp_good[q]);
        check_value($sformatf("bad_cnt[%0d]", q), 32'(bad_cnt[q*16 +: 16]), exp_bad[q]);
        check_value($sformatf("last_len[%0d]", q), 32'(last_len[q*8 +: 8]), exp_len[q]);
        check_value("any_err", 32'(any_err), 32'(exp_err));
    endtask

    // watchdog allows 20 cycles per beat plus margin
    initial begin
        int beats;
        beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            beats += (int'(rows[i].len) + 3) / 4;
        end
        repeat (16 + beats * 20 + 1000) @(posedge clk);
        $display("timeout: a packet never completed, errors so far %0d", err_cnt);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        start      = '0;
        pkt_len    = '0;
        first_byte = '0;
        err_inject = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // everything idle and cleared
        check_value("busy", 32'(busy), 32'h0);
        check_lane(0);
        check_lane(1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            launch_row(rows[i]);
            if (rows[i].pair) begin
                launch_row(rows[i+1]);
            end
            @(posedge clk);
            start <= '0;
            if (rows[i].restart) begin
                // lane is busy here so this pulse must be dropped
                @(posedge clk);
                start[rows[i].port] <= 1'b1;
                @(posedge clk);
                start <= '0;
            end
            wait_lane_done(int'(rows[i].port));
            if (rows[i].pair) begin
                wait_lane_done(int'(rows[i+1].port));
                check_lane(int'(rows[i+1].port));
            end
            check_lane(int'(rows[i].port));
            if (rows[i].pair) begin
                i++;
            end
        end
        // nothing may change over a few idle cycles
        repeat (20) @(negedge clk);
        check_lane(0);
        check_lane(1);
        $display("checks run %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
